//--- build.f
+incdir+include
design/fedp_pkg.sv
design/fedp_mul_exp.sv
design/fedp_align_acc.sv
design/fedp_norm.sv
design/fedp_arbiter.sv
design/fedp_core.sv
design/fedp_top.sv
bench/fedp_tb.sv

//--- bench/fedp_tb.sv
`include "fedp_config.svh"

module fedp_tb;
    import fedp_pkg::*;

    localparam int LAT = `FEDP_LATENCY;

    typedef struct {
        string       name;
        client_id_t  client;
        fedp_req_t   req;
        logic [31:0] want;
    } test_entry_t;

    logic                     clk;
    logic                     reset;
    logic                     c0_valid;
    logic                     c0_ready;
    logic [`FEDP_N-1:0][15:0] c0_a_row;
    logic [`FEDP_N-1:0][15:0] c0_b_col;
    logic [31:0]              c0_c_val;
    logic                     c1_valid;
    logic                     c1_ready;
    logic [`FEDP_N-1:0][15:0] c1_a_row;
    logic [`FEDP_N-1:0][15:0] c1_b_col;
    logic [31:0]              c1_c_val;
    logic                     rsp_valid;
    logic                     rsp_ready;
    logic [31:0]              rsp_data;
    client_id_t               rsp_client;

    test_entry_t tests[$];
    int          c0_pend[$];
    int          c1_pend[$];
    int          want_q[$];
    int          acc_cyc[$];
    int          errors;
    int          tests_run;
    bit          timed_out;
    logic [31:0] rng_state;

    fedp_top fedp_top_inst (
        .clk        (clk),
        .reset      (reset),
        .c0_valid   (c0_valid),
        .c0_ready   (c0_ready),
        .c0_a_row   (c0_a_row),
        .c0_b_col   (c0_b_col),
        .c0_c_val   (c0_c_val),
        .c1_valid   (c1_valid),
        .c1_ready   (c1_ready),
        .c1_a_row   (c1_a_row),
        .c1_b_col   (c1_b_col),
        .c1_c_val   (c1_c_val),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_client (rsp_client)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lane 1 sits in the upper half of a_pair and b_pair
    task automatic add_entry(input string name, input client_id_t client,
                             input logic [`FEDP_N*16-1:0] a_pair,
                             input logic [`FEDP_N*16-1:0] b_pair,
                             input logic [31:0] c, input logic [31:0] want);
        test_entry_t e;
        e.name      = name;
        e.client    = client;
        e.req.a_row = a_pair;
        e.req.b_col = b_pair;
        e.req.c_val = c;
        e.want      = want;
        tests.push_back(e);
    endtask

    task automatic check_data(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        if (got !== want) begin
            errors++;
            $display("ERR %s data expected %h actual %h", name, want, got);
        end
    endtask

    task automatic check_client(input string name, input client_id_t want,
                                input client_id_t got);
        if (got !== want) begin
            errors++;
            $display("ERR %s client expected %0d actual %0d", name, want, got);
        end
    endtask

    task automatic check_latency(input string name, input int want, input int got);
        if (got != want) begin
            errors++;
            $display("ERR %s latency expected %0d actual %0d", name, want, got);
        end
    endtask

    task automatic reset_dut();
        reset    = 1'b1;
        c0_valid = 1'b0;
        c1_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic drive_clients();
        if (c0_pend.size() != 0) begin
            c0_valid = 1'b1;
            c0_a_row = tests[c0_pend[0]].req.a_row;
            c0_b_col = tests[c0_pend[0]].req.b_col;
            c0_c_val = tests[c0_pend[0]].req.c_val;
        end else begin
            c0_valid = 1'b0;
        end
        if (c1_pend.size() != 0) begin
            c1_valid = 1'b1;
            c1_a_row = tests[c1_pend[0]].req.a_row;
            c1_b_col = tests[c1_pend[0]].req.b_col;
            c1_c_val = tests[c1_pend[0]].req.c_val;
        end else begin
            c1_valid = 1'b0;
        end
    endtask

    // Entries alternate 0,1,0,1 in the dual section, so table order is grant order
    task automatic run_phase(input string phase, input int first, input int count,
                             input int reps, input bit random_ready);
        int          cyc;
        int          settle;
        int          limit;
        int          idx;
        int          errs_before;
        bit          c0_acc;
        bit          c1_acc;
        bit          rsp_xfer;
        bit          held;
        logic [31:0] held_data;
        client_id_t  held_client;
        for (int r = 0; r < reps; r++) begin
            for (int i = first; i < first + count; i++) begin
                want_q.push_back(i);
                if (tests[i].client == client_id_t'(0)) begin
                    c0_pend.push_back(i);
                end else begin
                    c1_pend.push_back(i);
                end
            end
        end
        acc_cyc.delete();
        limit  = want_q.size() * 20 + 50;
        cyc    = 0;
        settle = 0;
        held   = 1'b0;
        drive_clients();
        rsp_ready = 1'b1;
        while ((want_q.size() != 0 || settle < LAT + 2) && !timed_out) begin
            if (cyc >= limit) begin
                $display("Timeout: phase %s did not return all of its responses", phase);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                c0_acc   = c0_valid && c0_ready;
                c1_acc   = c1_valid && c1_ready;
                rsp_xfer = rsp_valid && rsp_ready;
                if (held) begin
                    if (!rsp_valid) begin
                        errors++;
                        $display("rsp_valid dropped while the response was stalled");
                    end
                    check_data("stall_hold", held_data, rsp_data);
                    check_client("stall_hold", held_client, rsp_client);
                end
                held        = rsp_valid && !rsp_ready;
                held_data   = rsp_data;
                held_client = rsp_client;
                if (c0_acc || c1_acc) begin
                    acc_cyc.push_back(cyc);
                end
                if (rsp_xfer) begin
                    if (want_q.size() == 0 || acc_cyc.size() == 0) begin
                        errors++;
                        $display("A response arrived with no request outstanding");
                    end else begin
                        idx         = want_q.pop_front();
                        errs_before = errors;
                        tests_run++;
                        check_data(tests[idx].name, tests[idx].want, rsp_data);
                        check_client(tests[idx].name, tests[idx].client, rsp_client);
                        if (!random_ready) begin
                            check_latency(tests[idx].name, LAT, cyc - acc_cyc[0]);
                        end
                        void'(acc_cyc.pop_front());
                        if (errors == errs_before) begin
                            $display("ok %s client %0d data %h", tests[idx].name,
                                     rsp_client, rsp_data);
                        end
                    end
                end
                if (want_q.size() == 0) begin
                    settle++;
                end
                @(posedge clk);
                #1;
                if (c0_acc) begin
                    void'(c0_pend.pop_front());
                end
                if (c1_acc) begin
                    void'(c1_pend.pop_front());
                end
                drive_clients();
                if (random_ready && want_q.size() != 0) begin
                    rng_state = xorshift32(rng_state);
                    rsp_ready = rng_state[7];
                end else begin
                    rsp_ready = 1'b1;
                end
                cyc++;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        c0_valid  = 1'b0;
        c0_a_row  = '0;
        c0_b_col  = '0;
        c0_c_val  = '0;
        c1_valid  = 1'b0;
        c1_a_row  = '0;
        c1_b_col  = '0;
        c1_c_val  = '0;
        rsp_ready = 1'b1;
        errors    = 0;
        tests_run = 0;
        timed_out = 1'b0;
        rng_state = 32'd70822;

        // Client 0 alone in entries 0 to 14
        add_entry("dot_basic", 0, 32'h3400_3E00, 32'h4400_4000, 32'h3F80_0000, 32'h40A0_0000);
        add_entry("dot_neg", 0, 32'h4200_BC00, 32'h3C00_4000, 32'h3F00_0000, 32'h3FC0_0000);
        add_entry("dot_all_neg", 0, 32'hBC00_3C00, 32'h3C00_C000, 32'h0, 32'hC040_0000);
        add_entry("dot_neg_c", 0, 32'h4000_3800, 32'h4200_3800, 32'hC080_0000, 32'h4010_0000);
        add_entry("cancel_zero", 0, 32'hC000_4000, 32'h3C00_3C00, 32'h0, 32'h0);
        add_entry("cancel_c", 0, 32'h3C00_3C00, 32'h3C00_3C00, 32'hC000_0000, 32'h0);
        add_entry("small_c", 0, 32'h0000_3C00, 32'h0000_3C00, 32'h3080_0000, 32'h3F80_0000);
        add_entry("neg_trunc", 0, 32'h0000_BC00, 32'h0000_3C00, 32'hB080_0000, 32'hBF80_0000);
        add_entry("nan_operand", 0, 32'h3C00_7E00, 32'h3C00_3C00, 32'h0, 32'h7FC0_0000);
        add_entry("inf_cancel", 0, 32'hFC00_7C00, 32'h3C00_3C00, 32'h0, 32'h7FC0_0000);
        add_entry("inf_pos", 0, 32'h3C00_7C00, 32'h3C00_4000, 32'h3F80_0000, 32'h7F80_0000);
        add_entry("inf_neg", 0, 32'h0000_FC00, 32'h0000_3C00, 32'h0, 32'hFF80_0000);
        add_entry("inf_c", 0, 32'h0000_3C00, 32'h0000_3C00, 32'hFF80_0000, 32'hFF80_0000);
        add_entry("sub_flush", 0, 32'h3C00_0001, 32'h3C00_4400, 32'h0, 32'h3F80_0000);
        add_entry("sub_c", 0, 32'h0000_0000, 32'h0000_0000, 32'h0040_0000, 32'h0);
        // Entries 15 to 20 use both clients
        add_entry("dual_0a", 0, 32'h3C00_4000, 32'h3C00_4000, 32'h0, 32'h40A0_0000);
        add_entry("dual_1a", 1, 32'h0000_4200, 32'h0000_4200, 32'h3F80_0000, 32'h4120_0000);
        add_entry("dual_0b", 0, 32'h3C00_3800, 32'hBC00_4400, 32'h3F00_0000, 32'h3FC0_0000);
        add_entry("dual_1b", 1, 32'h0000_C200, 32'h0000_4000, 32'h0, 32'hC0C0_0000);
        add_entry("dual_0c", 0, 32'h4400_4400, 32'h4400_4400, 32'h0, 32'h4200_0000);
        add_entry("dual_1c", 1, 32'h0000_3E00, 32'h0000_3E00, 32'h0, 32'h4010_0000);

        reset_dut();
        run_phase("single", 0, 15, 1, 1'b0);
        // Pointer back to client 0 before both clients compete
        if (!timed_out) begin
            reset_dut();
            run_phase("dual", 15, 6, 1, 1'b0);
        end
        if (!timed_out) begin
            run_phase("backpressure", 15, 6, 4, 1'b1);
        end

        $display("Tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- design/fedp_top.sv
`include "fedp_config.svh"

module fedp_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       c0_valid,
    output logic                       c0_ready,
    input  logic [`FEDP_N-1:0][15:0]   c0_a_row,
    input  logic [`FEDP_N-1:0][15:0]   c0_b_col,
    input  logic [31:0]                c0_c_val,
    input  logic                       c1_valid,
    output logic                       c1_ready,
    input  logic [`FEDP_N-1:0][15:0]   c1_a_row,
    input  logic [`FEDP_N-1:0][15:0]   c1_b_col,
    input  logic [31:0]                c1_c_val,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output logic [31:0]                rsp_data,
    output fedp_pkg::client_id_t       rsp_client
);
    import fedp_pkg::*;

    fedp_req_if #(.payload_t(fedp_req_t)) c0_if ();
    fedp_req_if #(.payload_t(fedp_req_t)) c1_if ();
    fedp_req_if #(.payload_t(fedp_req_t)) core_if ();

    // Client ids follow the arbiter input position
    assign c0_if.valid   = c0_valid;
    assign c0_if.payload = '{a_row: c0_a_row, b_col: c0_b_col, c_val: c0_c_val};
    assign c0_if.client  = client_id_t'(0);
    assign c0_ready      = c0_if.ready;

    assign c1_if.valid   = c1_valid;
    assign c1_if.payload = '{a_row: c1_a_row, b_col: c1_b_col, c_val: c1_c_val};
    assign c1_if.client  = client_id_t'(1);
    assign c1_ready      = c1_if.ready;

    fedp_arbiter #(
        .payload_t (fedp_req_t)
    ) arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .req0      (c0_if.sink),
        .req1      (c1_if.sink),
        .grant_out (core_if.source)
    );

    fedp_core core_inst (
        .clk        (clk),
        .reset      (reset),
        .req        (core_if.sink),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_client (rsp_client)
    );

endmodule

//--- design/fedp_core.sv
`include "fedp_config.svh"

module fedp_core (
    input  logic                 clk,
    input  logic                 reset,
    fedp_req_if.sink             req,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output logic [31:0]          rsp_data,
    output fedp_pkg::client_id_t rsp_client
);
    import fedp_pkg::*;

    localparam int LAT   = `FEDP_LATENCY;
    localparam int TERMS = `FEDP_TERMS;
    localparam int EW    = `FEDP_EXP_W;
    localparam int SW    = `FEDP_SIG_W;
    localparam int SHW   = `FEDP_SHIFT_W;
    localparam int AW    = `FEDP_ACC_W;

    fedp_tagged_t   in_tag;
    logic           advance;
    logic           accept;
    logic [LAT-1:0] vld_r;
    client_id_t     cid_r [LAT];

    // Stage 1 outputs and registers
    logic [EW-1:0]             m_max_exp;
    logic [TERMS-1:0][SHW-1:0] m_shift;
    logic [TERMS-1:0][SW:0]    m_sigs;
    fedp_excep_t               m_exc;
    logic [EW-1:0]             s1_max_exp;
    logic [TERMS-1:0][SHW-1:0] s1_shift;
    logic [TERMS-1:0][SW:0]    s1_sigs;
    fedp_excep_t               s1_exc;

    // Stage 2
    logic signed [AW-1:0] a_acc;
    logic                 a_sticky;
    logic signed [AW-1:0] s2_acc;
    logic                 s2_sticky;
    logic [EW-1:0]        s2_max_exp;
    fedp_excep_t          s2_exc;

    // Stage 3
    logic [31:0] n_result;
    logic [31:0] s3_result;

    assign in_tag.req    = req.payload;
    assign in_tag.client = req.client;

    // Whole pipe holds while the output is blocked
    assign advance   = ~(rsp_valid & ~rsp_ready);
    assign req.ready = advance;
    assign accept    = req.valid & advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_r <= '0;
        end else if (advance) begin
            vld_r <= {vld_r[LAT-2:0], req.valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            cid_r[0] <= in_tag.client;
            for (int s = 1; s < LAT; s++) begin
                cid_r[s] <= cid_r[s-1];
            end
        end
    end

    fedp_mul_exp mul_exp_inst (
        .a_row      (in_tag.req.a_row),
        .b_col      (in_tag.req.b_col),
        .c_val      (in_tag.req.c_val),
        .max_exp    (m_max_exp),
        .shift_amt  (m_shift),
        .raw_sigs   (m_sigs),
        .exceptions (m_exc)
    );

    fedp_align_acc align_acc_inst (
        .shift_amt (s1_shift),
        .raw_sigs  (s1_sigs),
        .acc_sig   (a_acc),
        .sticky    (a_sticky)
    );

    fedp_norm norm_inst (
        .max_exp    (s2_max_exp),
        .acc_sig    (s2_acc),
        .sticky     (s2_sticky),
        .exceptions (s2_exc),
        .result     (n_result)
    );

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_max_exp <= m_max_exp;
            s1_shift   <= m_shift;
            s1_sigs    <= m_sigs;
            s1_exc     <= m_exc;
            s2_acc     <= a_acc;
            s2_sticky  <= a_sticky;
            s2_max_exp <= s1_max_exp;
            s2_exc     <= s1_exc;
            s3_result  <= n_result;
            rsp_data   <= s3_result;
        end
    end

    assign rsp_valid  = vld_r[LAT-1];
    assign rsp_client = cid_r[LAT-1];

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> ($stable(rsp_data) && $stable(rsp_client)));

    a_latency: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##1 (advance [-> LAT-1]) ##1 rsp_valid);

endmodule

//--- design/fedp_arbiter.sv
interface fedp_req_if #(
    parameter type payload_t = logic
);
    import fedp_pkg::*;

    logic       valid;
    logic       ready;
    payload_t   payload;
    client_id_t client;

    modport source (output valid, output payload, output client, input ready);
    modport sink (input valid, input payload, input client, output ready);

endinterface

module fedp_arbiter #(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        reset,
    fedp_req_if.sink    req0,
    fedp_req_if.sink    req1,
    fedp_req_if.source  grant_out
);
    // Low favors input 0
    logic     prio;
    logic     pick;
    logic     xfer;
    payload_t win_payload;

    always_comb begin
        if (req0.valid && req1.valid) begin
            pick = prio;
        end else begin
            pick = req1.valid;
        end
    end

    assign win_payload = pick ? req1.payload : req0.payload;

    assign grant_out.valid   = req0.valid | req1.valid;
    assign grant_out.payload = win_payload;
    assign grant_out.client  = pick ? req1.client : req0.client;

    assign req0.ready = grant_out.ready & req0.valid & ~pick;
    assign req1.ready = grant_out.ready & req1.valid & pick;

    assign xfer = grant_out.valid & grant_out.ready;

    // Pointer moves past the winner
    always_ff @(posedge clk) begin
        if (reset) begin
            prio <= 1'b0;
        end else if (xfer) begin
            prio <= ~pick;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        !(req0.ready && req1.ready));

    a_ready_valid: assert property (@(posedge clk) disable iff (reset)
        (req0.ready |-> req0.valid) and (req1.ready |-> req1.valid));

endmodule

//--- design/fedp_norm.sv
`include "fedp_config.svh"

module fedp_norm (
    input  logic [`FEDP_EXP_W-1:0]        max_exp,
    input  logic signed [`FEDP_ACC_W-1:0] acc_sig,
    input  logic                          sticky,
    input  fedp_pkg::fedp_excep_t         exceptions,
    output logic [31:0]                   result
);
    localparam int AW  = `FEDP_ACC_W;
    localparam int MW  = AW - 1;
    localparam int LZW = $clog2(MW) + 1;
    localparam int EXW = `FEDP_EXP_W + 2;

    logic                  neg;
    logic [MW-1:0]         mag;
    logic [LZW-1:0]        lzc;
    logic [MW-1:0]         norm_sig;
    logic signed [EXW-1:0] res_exp;

    assign neg = acc_sig[AW-1];

    // Floor sum sits below the exact value, one less keeps negatives toward zero
    assign mag = neg ? MW'(-acc_sig) - MW'(sticky) : MW'(acc_sig);

    always_comb begin
        lzc = LZW'(MW);
        for (int i = 0; i < MW; i++) begin
            if (mag[i]) begin
                lzc = LZW'(MW - 1 - i);
            end
        end
    end

    assign norm_sig = mag << lzc;

    // Top magnitude bit weighs 2^(MW-24) over the term exponent
    assign res_exp = $signed({2'b00, max_exp}) + EXW'(MW - 24) - $signed(EXW'(lzc));

    always_comb begin
        if (exceptions.is_nan) begin
            result = 32'h7FC0_0000;
        end else if (exceptions.is_inf) begin
            result = {exceptions.inf_sign, 8'hFF, 23'd0};
        end else if (mag == '0) begin
            result = 32'd0;
        end else if (res_exp <= 0) begin
            // Flush to signed zero
            result = {neg, 31'd0};
        end else if (res_exp >= 255) begin
            result = {neg, 8'hFF, 23'd0};
        end else begin
            result = {neg, res_exp[7:0], norm_sig[MW-2 -: 23]};
        end
    end

endmodule

//--- design/fedp_align_acc.sv
`include "fedp_config.svh"

module fedp_align_acc (
    input  logic [`FEDP_TERMS-1:0][`FEDP_SHIFT_W-1:0] shift_amt,
    input  logic [`FEDP_TERMS-1:0][`FEDP_SIG_W:0]     raw_sigs,
    output logic signed [`FEDP_ACC_W-1:0]             acc_sig,
    output logic                                      sticky
);
    localparam int TERMS = `FEDP_TERMS;
    localparam int SW    = `FEDP_SIG_W;
    localparam int AW    = `FEDP_ACC_W;

    logic [TERMS-1:0][SW-1:0] aligned;
    logic [TERMS-1:0]         lost;

    // Right shift onto the largest exponent
    always_comb begin
        logic [SW-1:0] mag;
        logic [SW-1:0] lost_mask;
        for (int t = 0; t < TERMS; t++) begin
            mag        = raw_sigs[t][SW-1:0];
            aligned[t] = mag >> shift_amt[t];
            lost_mask  = ~({SW{1'b1}} << shift_amt[t]);
            lost[t]    = |(mag & lost_mask);
        end
    end

    // A negative term with lost bits takes the floor
    // so the sum never sits above the exact value
    always_comb begin
        logic signed [AW-1:0] term;
        acc_sig = '0;
        for (int t = 0; t < TERMS; t++) begin
            term = signed'(AW'(aligned[t]));
            if (raw_sigs[t][SW]) begin
                term = lost[t] ? ~term : -term;
            end
            acc_sig = acc_sig + term;
        end
    end

    assign sticky = |lost;

endmodule

//--- design/fedp_mul_exp.sv
`include "fedp_config.svh"

module fedp_mul_exp (
    input  logic [`FEDP_N-1:0][15:0]                  a_row,
    input  logic [`FEDP_N-1:0][15:0]                  b_col,
    input  logic [31:0]                               c_val,
    output logic [`FEDP_EXP_W-1:0]                    max_exp,
    output logic [`FEDP_TERMS-1:0][`FEDP_SHIFT_W-1:0] shift_amt,
    output logic [`FEDP_TERMS-1:0][`FEDP_SIG_W:0]     raw_sigs,
    output fedp_pkg::fedp_excep_t                     exceptions
);
    localparam int N     = `FEDP_N;
    localparam int TERMS = `FEDP_TERMS;
    localparam int EW    = `FEDP_EXP_W;
    localparam int SW    = `FEDP_SIG_W;
    localparam int SHW   = `FEDP_SHIFT_W;

    // fp32 bias minus both fp16 biases
    localparam int PROD_BIAS = 127 - 15 - 15;

    logic [TERMS-1:0][EW-1:0] term_exp;
    logic [TERMS-1:0][SW-1:0] term_sig;
    logic [TERMS-1:0]         term_sign;
    logic [TERMS-1:0]         term_nan;
    logic [TERMS-1:0]         term_inf;
    logic                     pos_inf;
    logic                     neg_inf;
    logic                     any_nan;

    always_comb begin
        logic [4:0]  ea;
        logic [4:0]  eb;
        logic [10:0] ma;
        logic [10:0] mb;
        logic [21:0] prod;
        logic        a_zero;
        logic        b_zero;
        for (int i = 0; i < N; i++) begin
            ea = a_row[i][14:10];
            eb = b_col[i][14:10];
            a_zero = (ea == 5'd0);
            b_zero = (eb == 5'd0);
            // Subnormals flush to zero
            ma = a_zero ? 11'd0 : {1'b1, a_row[i][9:0]};
            mb = b_zero ? 11'd0 : {1'b1, b_col[i][9:0]};
            prod = ma * mb;
            term_sig[i]  = SW'({prod, 3'b000});
            term_exp[i]  = (a_zero || b_zero) ? '0 : EW'(ea) + EW'(eb) + EW'(PROD_BIAS);
            term_sign[i] = a_row[i][15] ^ b_col[i][15];
            term_nan[i]  = (ea == 5'h1F && a_row[i][9:0] != '0)
                        || (eb == 5'h1F && b_col[i][9:0] != '0)
                        || (ea == 5'h1F && b_zero)
                        || (eb == 5'h1F && a_zero);
            term_inf[i]  = (ea == 5'h1F || eb == 5'h1F) && !term_nan[i];
        end

        // Addend is the last term
        term_sig[N]  = (c_val[30:23] == 8'd0) ? '0 : SW'({1'b1, c_val[22:0]});
        term_exp[N]  = EW'(c_val[30:23]);
        term_sign[N] = c_val[31];
        term_nan[N]  = (c_val[30:23] == 8'hFF) && (c_val[22:0] != '0);
        term_inf[N]  = (c_val[30:23] == 8'hFF) && (c_val[22:0] == '0);
    end

    always_comb begin
        max_exp = '0;
        for (int t = 0; t < TERMS; t++) begin
            if (term_exp[t] > max_exp) begin
                max_exp = term_exp[t];
            end
        end
    end

    always_comb begin
        logic [EW-1:0] diff;
        for (int t = 0; t < TERMS; t++) begin
            diff = max_exp - term_exp[t];
            // Anything past the window shifts out entirely
            shift_amt[t] = ((diff >> SHW) != '0) ? '1 : diff[SHW-1:0];
            raw_sigs[t]  = {term_sign[t], term_sig[t]};
        end
    end

    assign any_nan = |term_nan;
    assign pos_inf = |(term_inf & ~term_sign);
    assign neg_inf = |(term_inf & term_sign);

    // Opposite infinities cancel into NaN
    assign exceptions.is_nan   = any_nan | (pos_inf & neg_inf);
    assign exceptions.is_inf   = (pos_inf | neg_inf) & ~any_nan & ~(pos_inf & neg_inf);
    assign exceptions.inf_sign = neg_inf;

endmodule

//--- design/fedp_pkg.sv
`include "fedp_config.svh"

package fedp_pkg;

    typedef logic [15:0] fp16_t;

    // Requesting client, position on the arbiter
    typedef logic client_id_t;

    typedef struct packed {
        fp16_t [`FEDP_N-1:0] a_row;
        fp16_t [`FEDP_N-1:0] b_col;
        logic [31:0]         c_val;
    } fedp_req_t;

    // Special value state carried alongside the sum
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic inf_sign;
    } fedp_excep_t;

    typedef struct packed {
        client_id_t client;
        fedp_req_t  req;
    } fedp_tagged_t;

endpackage

//--- include/fedp_config.svh
`ifndef FEDP_CONFIG_SVH
`define FEDP_CONFIG_SVH

// Operand pairs per request
`define FEDP_N 2

// Products plus the addend
`define FEDP_TERMS (`FEDP_N + 1)

// Request to response depth in cycles
`define FEDP_LATENCY 4

// Aligned significand, one integer bit above the fp32 hidden bit
`define FEDP_SIG_W 25

// Biased exponent, fp32 bias
`define FEDP_EXP_W 10

`define FEDP_SHIFT_W 8

// Room for sign and carries of all terms
`define FEDP_ACC_W (`FEDP_SIG_W + 1 + $clog2(`FEDP_TERMS))

`endif
